/* lc4_pipeline.f */
source/lc4_pkg.sv
source/lc4_decoder.sv
source/lc4_alu.sv
source/lc4_regfile.sv
source/lc4_hazard_unit.sv
source/lc4_pipeline.sv
tb/tb_lc4_pipeline.sv

/* Makefile */
VERILATOR := verilator
FLAGS     := --binary --timing --assert
TOP       := tb_lc4_pipeline
FILELIST  := lc4_pipeline.f
BUILD_DIR := obj_dir
BIN       := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BIN)

clean:
	rm -rf $(BUILD_DIR)

/* tb/tb_lc4_pipeline.sv */
// ==============================
// lc4 pipeline testbench
// runs one program against an isa model
// ==============================
`timescale 1ns/1ps

module tb_lc4_pipeline;
    import lc4_pkg::*;

    localparam int PROG_LEN = 22;
    localparam int MAX_WAIT = 40;

    logic     gwe;
    logic     rst;
    word_t    cur_pc;
    word_t    cur_insn;
    word_t    dmem_addr;
    word_t    dmem_towrite;
    word_t    cur_dmem_data;
    logic     dmem_we;
    word_t    wb_pc;
    word_t    wb_insn;
    stall_t   wb_stall;
    logic     rf_we;
    reg_idx_t rf_wsel;
    word_t    rf_data;

    word_t imem [0:63];
    word_t dmem [0:255];
    word_t model_mem [0:255];

    // expected retirements in program order, gap is the bubble count before each
    word_t  exp_pc[$];
    word_t  exp_insn[$];
    logic   exp_we[$];
    word_t  exp_wsel[$];
    word_t  exp_data[$];
    int     exp_gap[$];
    stall_t exp_code[$];
    word_t  exp_store_addr[$];
    word_t  exp_store_data[$];

    lc4_pipeline uut (
        .gwe(gwe), .i_rst(rst), .o_cur_pc(cur_pc), .i_cur_insn(cur_insn),
        .o_dmem_addr(dmem_addr), .o_dmem_towrite(dmem_towrite), .o_dmem_we(dmem_we),
        .i_cur_dmem_data(cur_dmem_data), .o_wb_pc(wb_pc), .o_wb_insn(wb_insn),
        .o_wb_stall(wb_stall), .o_rf_we(rf_we), .o_rf_wsel(rf_wsel), .o_rf_data(rf_data)
    );

    // both memories answer in the same cycle
    assign cur_insn      = (cur_pc[15:6] == PC_RESET[15:6]) ? imem[cur_pc[5:0]] : '0;
    assign cur_dmem_data = dmem[dmem_addr[7:0]];

    always @(posedge gwe) begin
        if (dmem_we) begin
            dmem[dmem_addr[7:0]] <= dmem_towrite;
        end
    end

    initial begin
        gwe = 1'b0;
        forever #4 gwe = ~gwe;
    end

    function automatic word_t reg_form(opcode_t op, reg_idx_t rd, reg_idx_t rs,
                                       logic [2:0] sub, reg_idx_t rt);
        return {op, rd, rs, sub, rt};
    endfunction

    function automatic word_t add_imm(reg_idx_t rd, reg_idx_t rs, logic [4:0] imm);
        return {OP_ARITH, rd, rs, 1'b1, imm};
    endfunction

    function automatic word_t mem_form(opcode_t op, reg_idx_t r, reg_idx_t rs,
                                       logic [5:0] imm);
        return {op, r, rs, imm};
    endfunction

    function automatic word_t const_insn(reg_idx_t rd, logic [8:0] imm);
        return {OP_CONST, rd, imm};
    endfunction

    function automatic word_t branch_insn(nzp_t mask, logic [8:0] imm);
        return {OP_BR, mask, imm};
    endfunction

    task automatic load_program();
        for (int i = 0; i < 64; i++) begin
            imem[i] = '0;
        end
        // dependent alu chain, mx wx and write-through
        imem[0]  = const_insn(3'd1, 9'd5);
        imem[1]  = const_insn(3'd2, 9'h1FE);
        imem[2]  = reg_form(OP_ARITH, 3'd3, 3'd1, ARITH_ADD, 3'd2);
        imem[3]  = reg_form(OP_ARITH, 3'd4, 3'd3, ARITH_SUB, 3'd1);
        imem[4]  = reg_form(OP_LOGIC, 3'd5, 3'd4, LOGIC_AND, 3'd3);
        imem[5]  = reg_form(OP_LOGIC, 3'd6, 3'd5, LOGIC_OR, 3'd4);
        imem[6]  = add_imm(3'd7, 3'd6, 5'd7);
        imem[7]  = reg_form(OP_ARITH, 3'd1, 3'd7, ARITH_ADD, 3'd5);
        // load then immediate use
        imem[8]  = const_insn(3'd0, 9'd16);
        imem[9]  = mem_form(OP_LDR, 3'd2, 3'd0, 6'd3);
        imem[10] = reg_form(OP_ARITH, 3'd3, 3'd2, ARITH_ADD, 3'd1);
        // stores right behind their data producers
        imem[11] = add_imm(3'd4, 3'd3, 5'd1);
        imem[12] = mem_form(OP_STR, 3'd4, 3'd0, 6'd5);
        imem[13] = mem_form(OP_LDR, 3'd5, 3'd0, 6'd5);
        imem[14] = mem_form(OP_STR, 3'd5, 3'd0, 6'd6);
        // taken BRz over two instructions, then an untaken BRzp
        imem[15] = reg_form(OP_ARITH, 3'd6, 3'd5, ARITH_SUB, 3'd5);
        imem[16] = branch_insn(3'b010, 9'd2);
        imem[17] = const_insn(3'd7, 9'd1);
        imem[18] = const_insn(3'd7, 9'd2);
        imem[19] = const_insn(3'd7, 9'h1FF);
        imem[20] = branch_insn(3'b011, 9'd1);
        imem[21] = reg_form(OP_ARITH, 3'd1, 3'd7, ARITH_ADD, 3'd1);
    endtask

    // sequential isa model of the kept instruction set
    task automatic run_model();
        word_t    regs [NUM_REGS];
        word_t    pc, insn, res, addr;
        word_t    imm5, imm6, imm9;
        nzp_t     nzp;
        reg_idx_t rd, rs, rt, prev_rd;
        logic     wr, rs_used, rt_used, prev_load, taken;
        int       gap;
        stall_t   code;
        pc        = PC_RESET;
        nzp       = '0;
        prev_load = 1'b0;
        prev_rd   = '0;
        // reset bubbles come first, their count is not fixed here
        gap       = -1;
        code      = STALL_FLUSH;
        for (int i = 0; i < NUM_REGS; i++) begin
            regs[i] = '0;
        end
        for (int step = 0; step < 64; step++) begin
            if (int'(pc - PC_RESET) >= PROG_LEN) begin
                break;
            end
            insn    = imem[pc[5:0]];
            rd      = insn[11:9];
            rs      = insn[8:6];
            rt      = insn[2:0];
            imm5    = {{11{insn[4]}}, insn[4:0]};
            imm6    = {{10{insn[5]}}, insn[5:0]};
            imm9    = {{7{insn[8]}}, insn[8:0]};
            res     = '0;
            wr      = 1'b0;
            rs_used = 1'b0;
            rt_used = 1'b0;
            taken   = 1'b0;
            case (insn[15:12])
                4'b0000: begin
                    taken = |(nzp & insn[11:9]);
                end
                4'b0001: begin
                    if (insn[5]) begin
                        res     = regs[rs] + imm5;
                        wr      = 1'b1;
                        rs_used = 1'b1;
                    end else if (insn[5:3] == 3'b000 || insn[5:3] == 3'b010) begin
                        res     = insn[4] ? regs[rs] - regs[rt] : regs[rs] + regs[rt];
                        wr      = 1'b1;
                        rs_used = 1'b1;
                        rt_used = 1'b1;
                    end
                end
                4'b0101: begin
                    if (insn[5:3] == 3'b000 || insn[5:3] == 3'b010) begin
                        res     = insn[4] ? (regs[rs] | regs[rt]) : (regs[rs] & regs[rt]);
                        wr      = 1'b1;
                        rs_used = 1'b1;
                        rt_used = 1'b1;
                    end
                end
                4'b0110: begin
                    addr    = regs[rs] + imm6;
                    res     = model_mem[addr[7:0]];
                    wr      = 1'b1;
                    rs_used = 1'b1;
                end
                4'b0111: begin
                    addr = regs[rs] + imm6;
                    model_mem[addr[7:0]] = regs[rd];
                    exp_store_addr.push_back(addr);
                    exp_store_data.push_back(regs[rd]);
                    rs_used = 1'b1;
                end
                4'b1001: begin
                    res = imm9;
                    wr  = 1'b1;
                end
                default: begin
                    wr = 1'b0;
                end
            endcase
            // a reader right behind a load waits one cycle
            if (prev_load && ((rs_used && rs == prev_rd) || (rt_used && rt == prev_rd))) begin
                gap  = 1;
                code = STALL_LOAD;
            end
            exp_pc.push_back(pc);
            exp_insn.push_back(insn);
            exp_we.push_back(wr);
            exp_wsel.push_back(word_t'(rd));
            exp_data.push_back(res);
            exp_gap.push_back(gap);
            exp_code.push_back(code);
            if (wr) begin
                regs[rd] = res;
                nzp = res[15] ? 3'b100 : ((res == '0) ? 3'b010 : 3'b001);
            end
            prev_load = (insn[15:12] == 4'b0110);
            prev_rd   = rd;
            gap       = 0;
            code      = STALL_NONE;
            if (taken) begin
                // the two younger fetches get squashed
                pc   = pc + 16'd1 + imm9;
                gap  = 2;
                code = STALL_FLUSH;
            end else begin
                pc = pc + 16'd1;
            end
        end
    endtask

    task automatic report_failure(string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_value(string name, word_t got, word_t expected);
        assert (got === expected)
            else report_failure($sformatf("error: %s = %h, expected %h", name, got, expected));
    endtask

    task automatic check_reset_state();
        check_value("o_cur_pc", cur_pc, PC_RESET);
        check_value("o_dmem_we", word_t'(dmem_we), '0);
        check_value("o_rf_we", word_t'(rf_we), '0);
        check_value("o_wb_stall", word_t'(wb_stall), word_t'(STALL_FLUSH));
    endtask

    task automatic check_store_port();
        if (dmem_we) begin
            assert (exp_store_addr.size() != 0)
                else report_failure("a store reached data memory when none was expected");
            check_value("o_dmem_addr", dmem_addr, exp_store_addr[0]);
            check_value("o_dmem_towrite", dmem_towrite, exp_store_data[0]);
            void'(exp_store_addr.pop_front());
            void'(exp_store_data.pop_front());
        end
    endtask

    task automatic check_retirements();
        int bubbles;
        for (int idx = 0; idx < exp_pc.size(); idx++) begin
            bubbles = 0;
            @(negedge gwe);
            check_store_port();
            while (wb_stall != STALL_NONE) begin
                check_value("o_wb_stall", word_t'(wb_stall), word_t'(exp_code[idx]));
                check_value("o_rf_we", word_t'(rf_we), '0);
                bubbles++;
                assert (bubbles < MAX_WAIT)
                    else report_failure("timed out waiting for the next instruction to retire");
                @(negedge gwe);
                check_store_port();
            end
            if (exp_gap[idx] >= 0) begin
                assert (bubbles == exp_gap[idx])
                    else report_failure($sformatf(
                        "retirement %0d came after %0d bubbles instead of %0d",
                        idx, bubbles, exp_gap[idx]));
            end
            check_value("o_wb_pc", wb_pc, exp_pc[idx]);
            check_value("o_wb_insn", wb_insn, exp_insn[idx]);
            check_value("o_rf_we", word_t'(rf_we), word_t'(exp_we[idx]));
            if (exp_we[idx]) begin
                check_value("o_rf_wsel", word_t'(rf_wsel), exp_wsel[idx]);
                check_value("o_rf_data", rf_data, exp_data[idx]);
            end
        end
    endtask

    initial begin
        rst <= 1'b1;
        void'($urandom(40531));
        load_program();
        for (int i = 0; i < 256; i++) begin
            model_mem[i] = word_t'($urandom);
            dmem[i] <= model_mem[i];
        end
        run_model();
        repeat (2) @(posedge gwe);
        rst <= 1'b0;
        @(negedge gwe);
        check_reset_state();
        check_retirements();
        if (exp_store_addr.size() == 0) begin
            $display("Simulation passed");
            $finish;
        end else begin
            report_failure("an expected store never reached data memory");
        end
    end

endmodule

/* source/lc4_pipeline.sv */
// ==============================
// lc4 five-stage pipeline top
// pc, stage registers, nzp and wb trace
// ==============================
`timescale 1ns/1ps

module lc4_pipeline (
    input  logic              gwe,
    input  logic              i_rst,
    output lc4_pkg::word_t    o_cur_pc,
    input  lc4_pkg::word_t    i_cur_insn,
    output lc4_pkg::word_t    o_dmem_addr,
    output lc4_pkg::word_t    o_dmem_towrite,
    output logic              o_dmem_we,
    input  lc4_pkg::word_t    i_cur_dmem_data,
    output lc4_pkg::word_t    o_wb_pc,
    output lc4_pkg::word_t    o_wb_insn,
    output lc4_pkg::stall_t   o_wb_stall,
    output logic              o_rf_we,
    output lc4_pkg::reg_idx_t o_rf_wsel,
    output lc4_pkg::word_t    o_rf_data
);
    import lc4_pkg::*;

    function automatic word_t pick_operand(fwd_sel_t sel, word_t rf_val, word_t m_val,
                                           word_t w_val);
        case (sel)
            FWD_FROM_M: return m_val;
            FWD_FROM_W: return w_val;
            default:    return rf_val;
        endcase
    endfunction

    word_t    pc_q, pc_next;
    word_t    d_pc_q, d_insn_q, d_rs_data, d_rt_data;
    stall_t   d_stall_q, x_stall_q, m_stall_q, w_stall_q;
    reg_idx_t d_rs_sel, d_rt_sel, d_rd_sel;
    logic     d_rs_re, d_rt_re, d_rd_we, d_nzp_we, d_is_load, d_is_store, d_is_branch;
    alu_op_t  d_alu_op, x_alu_op_q;
    word_t    x_pc_q, x_insn_q, x_rs_data_q, x_rt_data_q, x_rs_val, x_rt_val, x_result;
    reg_idx_t x_rs_sel_q, x_rt_sel_q, x_rd_sel_q;
    logic     x_rs_re_q, x_rt_re_q, x_rd_we_q, x_nzp_we_q;
    logic     x_is_load_q, x_is_store_q, x_is_branch_q, x_br_taken;
    word_t    m_pc_q, m_insn_q, m_alu_q, m_store_q, m_result;
    reg_idx_t m_rt_sel_q, m_rd_sel_q, w_rd_sel_q;
    logic     m_rd_we_q, m_nzp_we_q, m_is_load_q, m_is_store_q, w_rd_we_q;
    nzp_t     nzp_q, m_nzp, br_nzp;
    word_t    w_pc_q, w_insn_q, w_result_q;
    logic     stall, flush, fwd_store;
    fwd_sel_t fwd_rs, fwd_rt;

    // fetch: taken branch beats a load-use hold
    always_comb begin
        if (flush) begin
            pc_next = x_result;
        end else if (stall) begin
            pc_next = pc_q;
        end else begin
            pc_next = pc_q + 16'd1;
        end
    end

    always_ff @(posedge gwe) begin
        if (i_rst) begin
            pc_q <= PC_RESET;
        end else begin
            pc_q <= pc_next;
        end
    end

    always_ff @(posedge gwe) begin
        if (i_rst || flush) begin
            d_pc_q    <= '0;
            d_insn_q  <= '0;
            d_stall_q <= STALL_FLUSH;
        end else if (!stall) begin
            d_pc_q    <= pc_q;
            d_insn_q  <= i_cur_insn;
            d_stall_q <= STALL_NONE;
        end
    end

    lc4_decoder u_decoder (
        .i_insn(d_insn_q), .o_rs_sel(d_rs_sel), .o_rt_sel(d_rt_sel), .o_rd_sel(d_rd_sel),
        .o_rs_re(d_rs_re), .o_rt_re(d_rt_re), .o_rd_we(d_rd_we), .o_nzp_we(d_nzp_we),
        .o_is_load(d_is_load), .o_is_store(d_is_store), .o_is_branch(d_is_branch),
        .o_alu_op(d_alu_op)
    );

    lc4_regfile u_regfile (
        .gwe(gwe), .i_rst(i_rst), .i_rs_sel(d_rs_sel), .i_rt_sel(d_rt_sel),
        .o_rs_data(d_rs_data), .o_rt_data(d_rt_data),
        .i_wsel(w_rd_sel_q), .i_wdata(w_result_q), .i_we(w_rd_we_q)
    );

    // decode to execute, a stall or flush puts a bubble into X
    always_ff @(posedge gwe) begin
        if (i_rst || flush || stall) begin
            x_pc_q        <= '0;
            x_insn_q      <= '0;
            x_rs_re_q     <= 1'b0;
            x_rt_re_q     <= 1'b0;
            x_rd_we_q     <= 1'b0;
            x_nzp_we_q    <= 1'b0;
            x_is_load_q   <= 1'b0;
            x_is_store_q  <= 1'b0;
            x_is_branch_q <= 1'b0;
        end else begin
            x_pc_q        <= d_pc_q;
            x_insn_q      <= d_insn_q;
            x_rs_re_q     <= d_rs_re;
            x_rt_re_q     <= d_rt_re;
            x_rd_we_q     <= d_rd_we;
            x_nzp_we_q    <= d_nzp_we;
            x_is_load_q   <= d_is_load;
            x_is_store_q  <= d_is_store;
            x_is_branch_q <= d_is_branch;
        end
    end

    always_ff @(posedge gwe) begin
        if (i_rst || flush) begin
            x_stall_q <= STALL_FLUSH;
        end else if (stall) begin
            x_stall_q <= STALL_LOAD;
        end else begin
            x_stall_q <= d_stall_q;
        end
    end

    always_ff @(posedge gwe) begin
        x_rs_sel_q  <= d_rs_sel;
        x_rt_sel_q  <= d_rt_sel;
        x_rd_sel_q  <= d_rd_sel;
        x_alu_op_q  <= d_alu_op;
        x_rs_data_q <= d_rs_data;
        x_rt_data_q <= d_rt_data;
    end

    // mx and wx bypass into the alu operands
    assign x_rs_val = pick_operand(fwd_rs, x_rs_data_q, m_result, w_result_q);
    assign x_rt_val = pick_operand(fwd_rt, x_rt_data_q, m_result, w_result_q);

    lc4_alu u_alu (
        .i_insn(x_insn_q), .i_pc(x_pc_q), .i_rs_data(x_rs_val), .i_rt_data(x_rt_val),
        .i_alu_op(x_alu_op_q), .o_result(x_result)
    );

    // nzp being produced in M is newer than the register
    assign br_nzp     = m_nzp_we_q ? m_nzp : nzp_q;
    assign x_br_taken = x_is_branch_q && (|(br_nzp & x_insn_q[11:9]));

    lc4_hazard_unit u_hazard (
        .i_d_rs_sel(d_rs_sel), .i_d_rt_sel(d_rt_sel), .i_d_rs_re(d_rs_re),
        .i_d_rt_re(d_rt_re), .i_d_is_store(d_is_store),
        .i_x_rs_sel(x_rs_sel_q), .i_x_rt_sel(x_rt_sel_q), .i_x_rs_re(x_rs_re_q),
        .i_x_rt_re(x_rt_re_q), .i_x_rd_sel(x_rd_sel_q), .i_x_is_load(x_is_load_q),
        .i_x_br_taken(x_br_taken),
        .i_m_rt_sel(m_rt_sel_q), .i_m_is_store(m_is_store_q), .i_m_rd_sel(m_rd_sel_q),
        .i_m_rd_we(m_rd_we_q), .i_w_rd_sel(w_rd_sel_q), .i_w_rd_we(w_rd_we_q),
        .o_stall(stall), .o_flush(flush), .o_fwd_rs(fwd_rs), .o_fwd_rt(fwd_rt),
        .o_fwd_store(fwd_store)
    );

    always_ff @(posedge gwe) begin
        if (i_rst) begin
            m_pc_q       <= '0;
            m_insn_q     <= '0;
            m_stall_q    <= STALL_FLUSH;
            m_rd_we_q    <= 1'b0;
            m_nzp_we_q   <= 1'b0;
            m_is_load_q  <= 1'b0;
            m_is_store_q <= 1'b0;
        end else begin
            m_pc_q       <= x_pc_q;
            m_insn_q     <= x_insn_q;
            m_stall_q    <= x_stall_q;
            m_rd_we_q    <= x_rd_we_q;
            m_nzp_we_q   <= x_nzp_we_q;
            m_is_load_q  <= x_is_load_q;
            m_is_store_q <= x_is_store_q;
        end
    end

    always_ff @(posedge gwe) begin
        m_rt_sel_q <= x_rt_sel_q;
        m_rd_sel_q <= x_rd_sel_q;
        m_alu_q    <= x_result;
        m_store_q  <= x_rt_val;
    end

    // memory answers in the same cycle
    assign m_result       = m_is_load_q ? i_cur_dmem_data : m_alu_q;
    assign o_dmem_addr    = (m_is_load_q || m_is_store_q) ? m_alu_q : '0;
    assign o_dmem_we      = m_is_store_q;
    assign o_dmem_towrite = fwd_store ? w_result_q : m_store_q;

    always_comb begin
        if (m_result[WORD_W-1]) begin
            m_nzp = 3'b100;
        end else if (m_result == '0) begin
            m_nzp = 3'b010;
        end else begin
            m_nzp = 3'b001;
        end
    end

    always_ff @(posedge gwe) begin
        if (i_rst) begin
            nzp_q <= '0;
        end else if (m_nzp_we_q) begin
            nzp_q <= m_nzp;
        end
    end

    always_ff @(posedge gwe) begin
        if (i_rst) begin
            w_pc_q    <= '0;
            w_insn_q  <= '0;
            w_stall_q <= STALL_FLUSH;
            w_rd_we_q <= 1'b0;
        end else begin
            w_pc_q    <= m_pc_q;
            w_insn_q  <= m_insn_q;
            w_stall_q <= m_stall_q;
            w_rd_we_q <= m_rd_we_q;
        end
    end

    always_ff @(posedge gwe) begin
        w_rd_sel_q <= m_rd_sel_q;
        w_result_q <= m_result;
    end

    assign o_cur_pc   = pc_q;
    assign o_wb_pc    = w_pc_q;
    assign o_wb_insn  = w_insn_q;
    assign o_wb_stall = w_stall_q;
    assign o_rf_we    = w_rd_we_q;
    assign o_rf_wsel  = w_rd_sel_q;
    assign o_rf_data  = w_result_q;

endmodule

/* source/lc4_hazard_unit.sv */
// ==============================
// lc4 hazard unit
// load-use stall, flush and bypass selects
// ==============================
`timescale 1ns/1ps

module lc4_hazard_unit (
    input  lc4_pkg::reg_idx_t i_d_rs_sel,
    input  lc4_pkg::reg_idx_t i_d_rt_sel,
    input  logic              i_d_rs_re,
    input  logic              i_d_rt_re,
    input  logic              i_d_is_store,
    input  lc4_pkg::reg_idx_t i_x_rs_sel,
    input  lc4_pkg::reg_idx_t i_x_rt_sel,
    input  logic              i_x_rs_re,
    input  logic              i_x_rt_re,
    input  lc4_pkg::reg_idx_t i_x_rd_sel,
    input  logic              i_x_is_load,
    input  logic              i_x_br_taken,
    input  lc4_pkg::reg_idx_t i_m_rt_sel,
    input  logic              i_m_is_store,
    input  lc4_pkg::reg_idx_t i_m_rd_sel,
    input  logic              i_m_rd_we,
    input  lc4_pkg::reg_idx_t i_w_rd_sel,
    input  logic              i_w_rd_we,
    output logic              o_stall,
    output logic              o_flush,
    output lc4_pkg::fwd_sel_t o_fwd_rs,
    output lc4_pkg::fwd_sel_t o_fwd_rt,
    output logic              o_fwd_store
);
    import lc4_pkg::*;

    logic load_use;
    logic rs_hit_m;
    logic rs_hit_w;
    logic rt_hit_m;
    logic rt_hit_w;

    // store data in D is excluded, the wm path supplies it later
    assign load_use = i_x_is_load &&
                      ((i_d_rs_re && i_d_rs_sel == i_x_rd_sel) ||
                       (i_d_rt_re && !i_d_is_store && i_d_rt_sel == i_x_rd_sel));

    assign o_flush = i_x_br_taken;
    assign o_stall = load_use && !i_x_br_taken;

    assign rs_hit_m = i_x_rs_re && i_m_rd_we && (i_m_rd_sel == i_x_rs_sel);
    assign rs_hit_w = i_x_rs_re && i_w_rd_we && (i_w_rd_sel == i_x_rs_sel);
    assign rt_hit_m = i_x_rt_re && i_m_rd_we && (i_m_rd_sel == i_x_rt_sel);
    assign rt_hit_w = i_x_rt_re && i_w_rd_we && (i_w_rd_sel == i_x_rt_sel);

    // the younger producer in M wins over W
    always_comb begin
        if (rs_hit_m) begin
            o_fwd_rs = FWD_FROM_M;
        end else if (rs_hit_w) begin
            o_fwd_rs = FWD_FROM_W;
        end else begin
            o_fwd_rs = FWD_REGFILE;
        end
    end

    always_comb begin
        if (rt_hit_m) begin
            o_fwd_rt = FWD_FROM_M;
        end else if (rt_hit_w) begin
            o_fwd_rt = FWD_FROM_W;
        end else begin
            o_fwd_rt = FWD_REGFILE;
        end
    end

    assign o_fwd_store = i_m_is_store && i_w_rd_we && (i_w_rd_sel == i_m_rt_sel);

endmodule

/* source/lc4_regfile.sv */
// ==============================
// lc4 register file
// 2 read, 1 write, write-through
// ==============================
`timescale 1ns/1ps

module lc4_regfile (
    input  logic              gwe,
    input  logic              i_rst,
    input  lc4_pkg::reg_idx_t i_rs_sel,
    input  lc4_pkg::reg_idx_t i_rt_sel,
    output lc4_pkg::word_t    o_rs_data,
    output lc4_pkg::word_t    o_rt_data,
    input  lc4_pkg::reg_idx_t i_wsel,
    input  lc4_pkg::word_t    i_wdata,
    input  logic              i_we
);
    import lc4_pkg::*;

    word_t regs [NUM_REGS];

    always_ff @(posedge gwe) begin
        if (i_rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we) begin
            regs[i_wsel] <= i_wdata;
        end
    end

    // same-cycle write shows on the read ports, this is the wd bypass
    assign o_rs_data = (i_we && i_wsel == i_rs_sel) ? i_wdata : regs[i_rs_sel];
    assign o_rt_data = (i_we && i_wsel == i_rt_sel) ? i_wdata : regs[i_rt_sel];

endmodule

/* source/lc4_alu.sv */
// ==============================
// lc4 execute-stage alu
// ==============================
`timescale 1ns/1ps

module lc4_alu (
    input  lc4_pkg::word_t   i_insn,
    input  lc4_pkg::word_t   i_pc,
    input  lc4_pkg::word_t   i_rs_data,
    input  lc4_pkg::word_t   i_rt_data,
    input  lc4_pkg::alu_op_t i_alu_op,
    output lc4_pkg::word_t   o_result
);
    import lc4_pkg::*;

    word_t imm5;
    word_t imm6;
    word_t imm9;
    word_t add_b;

    assign imm5 = {{(WORD_W - 5){i_insn[4]}}, i_insn[4:0]};
    assign imm6 = {{(WORD_W - 6){i_insn[5]}}, i_insn[5:0]};
    // shared by CONST and the branch offset
    assign imm9 = {{(WORD_W - 9){i_insn[8]}}, i_insn[8:0]};

    // bit 5 picks the imm5 form of ADD
    assign add_b = i_insn[5] ? imm5 : i_rt_data;

    always_comb begin
        case (i_alu_op)
            ALU_ADD:       o_result = i_rs_data + add_b;
            ALU_SUB:       o_result = i_rs_data - i_rt_data;
            ALU_AND:       o_result = i_rs_data & i_rt_data;
            ALU_OR:        o_result = i_rs_data | i_rt_data;
            ALU_PASS_IMM:  o_result = imm9;
            ALU_ADDR:      o_result = i_rs_data + imm6;
            ALU_BR_TARGET: o_result = i_pc + 16'd1 + imm9;
            default:       o_result = '0;
        endcase
    end

endmodule

/* source/lc4_decoder.sv */
// ==============================
// lc4 decoder
// instruction word to selects, enables and alu op
// ==============================
`timescale 1ns/1ps

module lc4_decoder (
    input  lc4_pkg::word_t    i_insn,
    output lc4_pkg::reg_idx_t o_rs_sel,
    output lc4_pkg::reg_idx_t o_rt_sel,
    output lc4_pkg::reg_idx_t o_rd_sel,
    output logic              o_rs_re,
    output logic              o_rt_re,
    output logic              o_rd_we,
    output logic              o_nzp_we,
    output logic              o_is_load,
    output logic              o_is_store,
    output logic              o_is_branch,
    output lc4_pkg::alu_op_t  o_alu_op
);
    import lc4_pkg::*;

    opcode_t    opcode;
    logic [2:0] sub_op;

    assign opcode = opcode_t'(i_insn[15:12]);
    assign sub_op = i_insn[5:3];

    assign o_rs_sel = i_insn[8:6];
    assign o_rd_sel = i_insn[11:9];
    // a store carries its data register in the rd field
    assign o_rt_sel = (opcode == OP_STR) ? i_insn[11:9] : i_insn[2:0];

    always_comb begin
        o_rs_re     = 1'b0;
        o_rt_re     = 1'b0;
        o_rd_we     = 1'b0;
        o_is_load   = 1'b0;
        o_is_store  = 1'b0;
        o_is_branch = 1'b0;
        o_alu_op    = ALU_ADD;
        case (opcode)
            OP_BR: begin
                // nzp mask of zero is the nop encoding
                o_is_branch = |i_insn[11:9];
                o_alu_op    = ALU_BR_TARGET;
            end
            OP_ARITH: begin
                if (i_insn[5]) begin
                    o_rs_re = 1'b1;
                    o_rd_we = 1'b1;
                end else if (sub_op == ARITH_ADD || sub_op == ARITH_SUB) begin
                    o_rs_re = 1'b1;
                    o_rt_re = 1'b1;
                    o_rd_we = 1'b1;
                    if (sub_op == ARITH_SUB) begin
                        o_alu_op = ALU_SUB;
                    end
                end
            end
            OP_LOGIC: begin
                if (sub_op == LOGIC_AND || sub_op == LOGIC_OR) begin
                    o_rs_re  = 1'b1;
                    o_rt_re  = 1'b1;
                    o_rd_we  = 1'b1;
                    o_alu_op = (sub_op == LOGIC_OR) ? ALU_OR : ALU_AND;
                end
            end
            OP_LDR: begin
                o_rs_re   = 1'b1;
                o_rd_we   = 1'b1;
                o_is_load = 1'b1;
                o_alu_op  = ALU_ADDR;
            end
            OP_STR: begin
                o_rs_re    = 1'b1;
                o_rt_re    = 1'b1;
                o_is_store = 1'b1;
                o_alu_op   = ALU_ADDR;
            end
            OP_CONST: begin
                o_rd_we  = 1'b1;
                o_alu_op = ALU_PASS_IMM;
            end
            default: begin
                o_rd_we = 1'b0;
            end
        endcase
    end

    // every register writer in the kept set also sets nzp
    assign o_nzp_we = o_rd_we;

endmodule

/* source/lc4_pkg.sv */
// ==============================
// lc4 shared definitions
// widths, reset pc and the pipeline enums
// ==============================
package lc4_pkg;

    localparam int WORD_W   = 16;
    localparam int NUM_REGS = 8;

    typedef logic [WORD_W-1:0]           word_t;
    typedef logic [$clog2(NUM_REGS)-1:0] reg_idx_t;

    // negative, zero, positive from msb to lsb
    typedef logic [2:0] nzp_t;

    localparam word_t PC_RESET = 16'h8200;

    // sub-function field in bits 5 to 3 of the arith and logic groups
    localparam logic [2:0] ARITH_ADD = 3'b000;
    localparam logic [2:0] ARITH_SUB = 3'b010;
    localparam logic [2:0] LOGIC_AND = 3'b000;
    localparam logic [2:0] LOGIC_OR  = 3'b010;

    typedef enum logic [3:0] {
        OP_BR    = 4'b0000,
        OP_ARITH = 4'b0001,
        OP_LOGIC = 4'b0101,
        OP_LDR   = 4'b0110,
        OP_STR   = 4'b0111,
        OP_CONST = 4'b1001
    } opcode_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_PASS_IMM,
        ALU_ADDR,
        ALU_BR_TARGET
    } alu_op_t;

    // code 1 was the second-pipe stall and has no use here
    typedef enum logic [1:0] {
        STALL_NONE  = 2'd0,
        STALL_FLUSH = 2'd2,
        STALL_LOAD  = 2'd3
    } stall_t;

    typedef enum logic [1:0] {
        FWD_REGFILE,
        FWD_FROM_M,
        FWD_FROM_W
    } fwd_sel_t;

endpackage
